//--- source/rv_exec_config.svh
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

// Register width of the core
`define RV_EXEC_XLEN 32

// 1 forwards the previous ALU result into the next operation
`define RV_EXEC_FORWARD 1

`endif

//--- source/rv_exec_pkg.sv
`include "rv_exec_config.svh"

package rv_exec_pkg;

    typedef logic [`RV_EXEC_XLEN-1:0] xlen_t;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 of BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Access size in funct3[1:0] of loads and stores, funct3[2] is unsigned
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;

    typedef enum logic [1:0] {
        EXEC_ALU, EXEC_LOAD, EXEC_STORE, EXEC_BRANCH
    } exec_type_e;

    typedef struct packed {
        logic [31:0] instr;
        xlen_t       rs1_value;
        xlen_t       rs2_value;
    } issue_t;

    typedef struct packed {
        exec_type_e  op_type;
        logic [2:0]  funct3;
        logic        alt;       // SUB and SRA/SRAI
        logic [4:0]  rd;
        xlen_t       imm;
        xlen_t       rs1_value;
        xlen_t       rs2_value; // immediate for OP-IMM
        logic        reuse_rs1;
        logic        reuse_rs2;
    } exec_op_t;

    typedef struct packed {
        logic                     read_enable;
        logic [3:0]               write_mask;
        logic [`RV_EXEC_XLEN-3:0] addr;  // Word address
        xlen_t                    data;
    } mem_req_t;

    typedef struct packed {
        logic [4:0] rd;
        logic [2:0] funct3;
        logic [1:0] offset;
    } load_cmd_t;

    typedef struct packed {
        logic [4:0] rd;
        xlen_t      value;
    } alu_result_t;

    typedef struct packed {
        logic  taken;
        xlen_t rel_addr;
    } branch_t;

    typedef struct packed {
        logic [4:0] rd;
        xlen_t      value;
    } writeback_t;

endpackage

//--- source/rv_stream_reg.sv
`timescale 1ns/1ps

module rv_stream_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_payload,
    input  logic     out_ready
);

    // Refill in the same cycle the held item leaves
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_payload <= in_payload;
        end
    end

    payload_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_payload));

endmodule

//--- source/rv_decode.sv
`timescale 1ns/1ps
`include "rv_exec_config.svh"

module rv_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  rv_exec_pkg::issue_t   issue,
    output logic                  issue_ready,
    output logic                  op_valid,
    output rv_exec_pkg::exec_op_t op,
    input  logic                  op_ready
);
    import rv_exec_pkg::*;

    localparam int XLEN = `RV_EXEC_XLEN;
    localparam bit FORWARD = (`RV_EXEC_FORWARD != 0);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] last_alu_rd;  // x0 means nothing to forward
    logic       is_alu;
    logic       uses_rs2;
    logic       supported;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    exec_op_t   next_op;

    assign opcode = issue.instr[6:0];
    assign rd     = issue.instr[11:7];
    assign funct3 = issue.instr[14:12];
    assign rs1    = issue.instr[19:15];
    assign rs2    = issue.instr[24:20];

    assign imm_i = {{(XLEN-12){issue.instr[31]}}, issue.instr[31:20]};
    assign imm_s = {{(XLEN-12){issue.instr[31]}}, issue.instr[31:25], issue.instr[11:7]};
    assign imm_b = {{(XLEN-13){issue.instr[31]}}, issue.instr[31], issue.instr[7],
                    issue.instr[30:25], issue.instr[11:8], 1'b0};

    always_comb begin
        next_op = '0;
        next_op.funct3 = funct3;
        next_op.rd = rd;
        next_op.rs1_value = issue.rs1_value;
        next_op.rs2_value = issue.rs2_value;
        is_alu = 1'b0;
        uses_rs2 = 1'b0;
        supported = 1'b1;

        case (opcode)
            OPC_OP: begin
                next_op.op_type = EXEC_ALU;
                next_op.alt = issue.instr[30];
                is_alu = 1'b1;
                uses_rs2 = 1'b1;
            end
            OPC_OP_IMM: begin
                next_op.op_type = EXEC_ALU;
                next_op.alt = issue.instr[30] && (funct3 == F3_SRL_SRA);  // SRAI only
                next_op.imm = imm_i;
                next_op.rs2_value = imm_i;
                is_alu = 1'b1;
            end
            OPC_LOAD: begin
                next_op.op_type = EXEC_LOAD;
                next_op.imm = imm_i;
            end
            OPC_STORE: begin
                next_op.op_type = EXEC_STORE;
                next_op.imm = imm_s;
                uses_rs2 = 1'b1;
            end
            OPC_BRANCH: begin
                next_op.op_type = EXEC_BRANCH;
                next_op.imm = imm_b;
                uses_rs2 = 1'b1;
            end
            default: supported = 1'b0;
        endcase

        next_op.reuse_rs1 = FORWARD && (last_alu_rd != '0) && (rs1 == last_alu_rd);
        next_op.reuse_rs2 = FORWARD && uses_rs2 && (last_alu_rd != '0) && (rs2 == last_alu_rd);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_alu_rd <= '0;
        end else if (issue_valid && issue_ready) begin
            last_alu_rd <= is_alu ? rd : '0;
        end
    end

    rv_stream_reg #(
        .payload_t(exec_op_t)
    ) op_reg_inst (
        .clk,
        .reset,
        .in_valid(issue_valid),
        .in_payload(next_op),
        .in_ready(issue_ready),
        .out_valid(op_valid),
        .out_payload(op),
        .out_ready(op_ready)
    );

    opcode_supported: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> supported)
        else $error("unsupported opcode %b", opcode);

endmodule

//--- source/rv_execute.sv
`timescale 1ns/1ps
`include "rv_exec_config.svh"

module rv_execute (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     op_valid,
    input  rv_exec_pkg::exec_op_t    op,
    output logic                     op_ready,
    output logic                     mem_req_valid,
    output rv_exec_pkg::mem_req_t    mem_req,
    input  logic                     mem_req_ready,
    output logic                     load_cmd_valid,
    output rv_exec_pkg::load_cmd_t   load_cmd,
    input  logic                     load_cmd_ready,
    output logic                     alu_res_valid,
    output rv_exec_pkg::alu_result_t alu_res,
    input  logic                     alu_res_ready,
    output logic                     branch_valid,
    output rv_exec_pkg::branch_t     branch,
    input  logic                     branch_ready
);
    import rv_exec_pkg::*;

    localparam int XLEN = `RV_EXEC_XLEN;
    localparam int SHW = $clog2(XLEN);

    // Bit positions in the per-output vectors
    localparam int OUT_MEM    = 3;
    localparam int OUT_LOAD   = 2;
    localparam int OUT_ALU    = 1;
    localparam int OUT_BRANCH = 0;

    typedef struct packed {
        xlen_t add_sub;
        xlen_t sll;
        xlen_t srl_sra;
        xlen_t xor_v;
        xlen_t or_v;
        xlen_t and_v;
        logic  eq;
        logic  lt;
        logic  ltu;
    } math_t;

    function automatic math_t get_math(xlen_t a, xlen_t b, logic alt);
        math_t r;
        r.add_sub = alt ? a - b : a + b;
        r.sll     = a << b[SHW-1:0];
        r.srl_sra = alt ? xlen_t'($signed(a) >>> b[SHW-1:0]) : a >> b[SHW-1:0];
        r.xor_v   = a ^ b;
        r.or_v    = a | b;
        r.and_v   = a & b;
        r.eq      = (a == b);
        r.lt      = ($signed(a) < $signed(b));
        r.ltu     = (a < b);
        return r;
    endfunction

    logic [3:0]  produce;
    logic [3:0]  out_valid;
    logic [3:0]  out_taken;
    logic [3:0]  out_free;
    logic        order_hold;
    logic        fire;
    xlen_t       a;
    xlen_t       b;
    xlen_t       store_data;
    logic [3:0]  store_mask;
    logic [1:0]  offset;
    math_t       m;
    alu_result_t next_alu;
    branch_t     next_branch;
    mem_req_t    next_mem;

    // Forwarded operands come from the held ALU result
    assign a = op.reuse_rs1 ? alu_res.value : op.rs1_value;
    assign b = op.reuse_rs2 ? alu_res.value : op.rs2_value;
    assign m = get_math(a, (op.op_type inside {EXEC_LOAD, EXEC_STORE}) ? op.imm : b,
                        (op.op_type == EXEC_ALU) && op.alt);
    assign offset = m.add_sub[1:0];

    always_comb begin
        next_alu.rd = op.rd;
        case (op.funct3)
            F3_ADD_SUB: next_alu.value = m.add_sub;
            F3_SLL:     next_alu.value = m.sll;
            F3_SLT:     next_alu.value = xlen_t'(m.lt);
            F3_SLTU:    next_alu.value = xlen_t'(m.ltu);
            F3_XOR:     next_alu.value = m.xor_v;
            F3_SRL_SRA: next_alu.value = m.srl_sra;
            F3_OR:      next_alu.value = m.or_v;
            F3_AND:     next_alu.value = m.and_v;
        endcase
    end

    always_comb begin
        next_branch.rel_addr = op.imm;
        case (op.funct3)
            F3_BEQ:  next_branch.taken = m.eq;
            F3_BNE:  next_branch.taken = !m.eq;
            F3_BLT:  next_branch.taken = m.lt;
            F3_BGE:  next_branch.taken = !m.lt;
            F3_BLTU: next_branch.taken = m.ltu;
            F3_BGEU: next_branch.taken = !m.ltu;
            default: next_branch.taken = 1'b0;
        endcase
    end

    // Store data shifted onto the lanes picked by the address offset
    always_comb begin
        case (op.funct3[1:0])
            SIZE_BYTE: begin
                store_data = {{(XLEN-8){1'b0}}, b[7:0]} << {offset, 3'b000};
                store_mask = 4'b0001 << offset;
            end
            SIZE_HALF: begin
                store_data = {{(XLEN-16){1'b0}}, b[15:0]} << {offset[1], 4'b0000};
                store_mask = 4'b0011 << {offset[1], 1'b0};
            end
            default: begin
                store_data = b;
                store_mask = 4'b1111;
            end
        endcase
    end

    always_comb begin
        next_mem.read_enable = (op.op_type == EXEC_LOAD);
        next_mem.write_mask = (op.op_type == EXEC_STORE) ? store_mask : 4'b0000;
        next_mem.addr = m.add_sub[XLEN-1:2];
        next_mem.data = (op.op_type == EXEC_STORE) ? store_data : '0;
    end

    always_comb begin
        produce = '0;
        case (op.op_type)
            EXEC_ALU:    produce[OUT_ALU] = 1'b1;
            EXEC_LOAD:   produce[OUT_MEM] = 1'b1;
            EXEC_STORE:  produce[OUT_MEM] = 1'b1;
            EXEC_BRANCH: produce[OUT_BRANCH] = 1'b1;
        endcase
        produce[OUT_LOAD] = (op.op_type == EXEC_LOAD);
    end

    // A load request waits for its tag to reach writeback, so the response finds it
    assign mem_req_valid = out_valid[OUT_MEM] &&
                           !(mem_req.read_enable && out_valid[OUT_LOAD] && !load_cmd_ready);
    assign load_cmd_valid = out_valid[OUT_LOAD];
    assign alu_res_valid  = out_valid[OUT_ALU];
    assign branch_valid   = out_valid[OUT_BRANCH];

    assign out_taken = {mem_req_valid & mem_req_ready, load_cmd_valid & load_cmd_ready,
                        alu_res_valid & alu_res_ready, branch_valid & branch_ready};
    assign out_free = ~out_valid | out_taken;

    // ALU results and load tags go out one at a time to keep writeback in order
    assign order_hold = produce[OUT_ALU] | produce[OUT_LOAD];
    assign op_ready = (&(out_free | ~produce)) &&
                      (!order_hold || (out_free[OUT_ALU] && out_free[OUT_LOAD]));
    assign fire = op_valid && op_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= '0;
        end else begin
            out_valid <= (out_valid & ~out_taken) | (produce & {4{fire}});
        end
    end

    always_ff @(posedge clk) begin
        if (fire && produce[OUT_MEM]) begin
            mem_req <= next_mem;
        end
        if (fire && produce[OUT_LOAD]) begin
            load_cmd <= '{rd: op.rd, funct3: op.funct3, offset: offset};
        end
        if (fire && produce[OUT_ALU]) begin
            alu_res <= next_alu;  // Also the forwarding source
        end
        if (fire && produce[OUT_BRANCH]) begin
            branch <= next_branch;
        end
    end

    mem_req_one_kind: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> !(mem_req.read_enable && (mem_req.write_mask != 4'b0000)));

    alu_load_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(alu_res_valid && load_cmd_valid));

endmodule

//--- source/rv_writeback.sv
`timescale 1ns/1ps
`include "rv_exec_config.svh"

module rv_writeback (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     alu_res_valid,
    input  rv_exec_pkg::alu_result_t alu_res,
    output logic                     alu_res_ready,
    input  logic                     load_cmd_valid,
    input  rv_exec_pkg::load_cmd_t   load_cmd,
    output logic                     load_cmd_ready,
    input  logic                     mem_rsp_valid,
    input  logic [`RV_EXEC_XLEN-1:0] mem_rsp_data,
    output logic                     wb_valid,
    output rv_exec_pkg::writeback_t  wb,
    input  logic                     wb_ready
);
    import rv_exec_pkg::*;

    localparam int XLEN = `RV_EXEC_XLEN;

    load_cmd_t  pend;
    logic       pending;
    logic       rsp_held;   // Response arrived while wb was full
    xlen_t      rsp_q;
    xlen_t      raw;
    xlen_t      shifted;
    xlen_t      load_value;
    logic       sign;
    logic       load_ready;
    logic       load_done;
    logic       wb_in_valid;
    logic       wb_in_ready;
    writeback_t wb_in;

    assign raw = rsp_held ? rsp_q : mem_rsp_data;
    assign shifted = raw >> {pend.offset, 3'b000};

    always_comb begin
        case (pend.funct3[1:0])
            SIZE_BYTE: begin
                sign = !pend.funct3[2] && shifted[7];
                load_value = {{(XLEN-8){sign}}, shifted[7:0]};
            end
            SIZE_HALF: begin
                sign = !pend.funct3[2] && shifted[15];
                load_value = {{(XLEN-16){sign}}, shifted[15:0]};
            end
            default: begin
                sign = 1'b0;
                load_value = shifted;
            end
        endcase
    end

    // Writes to x0 are consumed without reaching wb
    assign load_ready = pending && (rsp_held || mem_rsp_valid);
    assign load_done = load_ready && (wb_in_ready || pend.rd == '0);
    assign load_cmd_ready = !pending;
    assign alu_res_ready = !pending && (wb_in_ready || alu_res.rd == '0);

    assign wb_in_valid = pending ? (load_ready && pend.rd != '0)
                                 : (alu_res_valid && alu_res.rd != '0);
    assign wb_in.rd = pending ? pend.rd : alu_res.rd;
    assign wb_in.value = pending ? load_value : alu_res.value;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            rsp_held <= 1'b0;
        end else begin
            if (load_cmd_valid && load_cmd_ready) begin
                pending <= 1'b1;
            end else if (load_done) begin
                pending <= 1'b0;
            end
            rsp_held <= load_ready && !load_done;
        end
    end

    always_ff @(posedge clk) begin
        if (load_cmd_valid && load_cmd_ready) begin
            pend <= load_cmd;
        end
        if (mem_rsp_valid) begin
            rsp_q <= mem_rsp_data;
        end
    end

    rv_stream_reg #(
        .payload_t(writeback_t)
    ) wb_reg_inst (
        .clk,
        .reset,
        .in_valid(wb_in_valid),
        .in_payload(wb_in),
        .in_ready(wb_in_ready),
        .out_valid(wb_valid),
        .out_payload(wb),
        .out_ready(wb_ready)
    );

    // Each response must meet its own tag with no older data still held
    rsp_has_tag: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid |-> pending && !rsp_held);

endmodule

//--- source/rv_exec_top.sv
`timescale 1ns/1ps
`include "rv_exec_config.svh"

module rv_exec_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     issue_valid,
    input  rv_exec_pkg::issue_t      issue,
    output logic                     issue_ready,
    output logic                     mem_req_valid,
    output rv_exec_pkg::mem_req_t    mem_req,
    input  logic                     mem_req_ready,
    output logic                     branch_valid,
    output rv_exec_pkg::branch_t     branch,
    input  logic                     branch_ready,
    output logic                     wb_valid,
    output rv_exec_pkg::writeback_t  wb,
    input  logic                     wb_ready,
    input  logic                     mem_rsp_valid,
    input  logic [`RV_EXEC_XLEN-1:0] mem_rsp_data
);
    import rv_exec_pkg::*;

    logic        op_valid;
    logic        op_ready;
    exec_op_t    op;
    logic        load_cmd_valid;
    logic        load_cmd_ready;
    load_cmd_t   load_cmd;
    logic        alu_res_valid;
    logic        alu_res_ready;
    alu_result_t alu_res;

    rv_decode rv_decode_inst (
        .clk, .reset,
        .issue_valid, .issue, .issue_ready,
        .op_valid, .op, .op_ready
    );

    rv_execute rv_execute_inst (
        .clk, .reset,
        .op_valid, .op, .op_ready,
        .mem_req_valid, .mem_req, .mem_req_ready,
        .load_cmd_valid, .load_cmd, .load_cmd_ready,
        .alu_res_valid, .alu_res, .alu_res_ready,
        .branch_valid, .branch, .branch_ready
    );

    rv_writeback rv_writeback_inst (
        .clk, .reset,
        .alu_res_valid, .alu_res, .alu_res_ready,
        .load_cmd_valid, .load_cmd, .load_cmd_ready,
        .mem_rsp_valid, .mem_rsp_data,
        .wb_valid, .wb, .wb_ready
    );

endmodule

//--- dv/rv_exec_tb.sv
`timescale 1ns/1ps

module rv_exec_tb;
    import rv_exec_pkg::*;

    localparam logic [1:0] KIND_WB     = 2'd0;
    localparam logic [1:0] KIND_BRANCH = 2'd1;
    localparam logic [1:0] KIND_STORE  = 2'd2;
    localparam logic [1:0] KIND_NONE   = 2'd3;
    localparam logic [2:0] F3_B  = 3'd0;
    localparam logic [2:0] F3_H  = 3'd1;
    localparam logic [2:0] F3_W  = 3'd2;
    localparam logic [2:0] F3_BU = 3'd4;
    localparam logic [2:0] F3_HU = 3'd5;
    localparam logic [31:0] OPND_A = 32'h8765_4321;
    localparam logic [31:0] OPND_B = 32'h0000_0024;  // Shift amount 4

    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] instr;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
        logic [31:0] value;  // wb value, branch offset or store byte address
        logic [31:0] data;
        logic [3:0]  mask;
        logic        taken;
    } row_t;

    logic       clk;
    logic       reset;
    logic       issue_valid;
    issue_t     issue;
    logic       issue_ready;
    logic       mem_req_valid;
    mem_req_t   mem_req;
    logic       mem_req_ready;
    logic       branch_valid;
    branch_t    branch;
    logic       branch_ready;
    logic       wb_valid;
    writeback_t wb;
    logic       wb_ready;
    logic       mem_rsp_valid;
    xlen_t      mem_rsp_data;

    row_t       table_q[$];
    writeback_t wb_exp[$];
    branch_t    branch_exp[$];
    mem_req_t   mem_exp[$];
    xlen_t      mem [0:63];
    integer     seed;
    int         timeout_limit;
    int         next_row;
    logic       rsp_due;
    xlen_t      rsp_word;

    rv_exec_top rv_exec_top_inst (
        .clk, .reset,
        .issue_valid, .issue, .issue_ready,
        .mem_req_valid, .mem_req, .mem_req_ready,
        .branch_valid, .branch, .branch_ready,
        .wb_valid, .wb, .wb_ready,
        .mem_rsp_valid, .mem_rsp_data
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Stores and branches always name x1 and x2
    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    task automatic wb_row(input logic [31:0] instr, rs1_value, rs2_value, value);
        table_q.push_back({KIND_WB, instr, rs1_value, rs2_value, value, 32'h0, 4'h0, 1'b0});
    endtask

    task automatic silent_row(input logic [31:0] instr, rs1_value, rs2_value);
        table_q.push_back({KIND_NONE, instr, rs1_value, rs2_value, 32'h0, 32'h0, 4'h0, 1'b0});
    endtask

    task automatic branch_row(input logic [31:0] instr, rs1_value, rs2_value,
                              input logic taken, input logic [31:0] rel);
        table_q.push_back({KIND_BRANCH, instr, rs1_value, rs2_value, rel, 32'h0, 4'h0, taken});
    endtask

    task automatic store_row(input logic [31:0] instr, rs1_value, rs2_value, addr,
                             input logic [3:0] mask, input logic [31:0] data);
        table_q.push_back({KIND_STORE, instr, rs1_value, rs2_value, addr, data, mask, 1'b0});
    endtask

    task automatic build_table();
        wb_row(r_type(7'h00, 2, 1, F3_ADD_SUB, 10), OPND_A, OPND_B, 32'h8765_4345);
        wb_row(r_type(7'h20, 2, 1, F3_ADD_SUB, 11), OPND_A, OPND_B, 32'h8765_42fd);
        wb_row(r_type(7'h00, 2, 1, F3_SLL, 12), OPND_A, OPND_B, 32'h7654_3210);
        wb_row(r_type(7'h00, 2, 1, F3_SLT, 13), OPND_A, OPND_B, 32'h0000_0001);
        wb_row(r_type(7'h00, 2, 1, F3_SLTU, 14), OPND_A, OPND_B, 32'h0000_0000);
        wb_row(r_type(7'h00, 2, 1, F3_XOR, 15), OPND_A, OPND_B, 32'h8765_4305);
        wb_row(r_type(7'h00, 2, 1, F3_SRL_SRA, 16), OPND_A, OPND_B, 32'h0876_5432);
        wb_row(r_type(7'h20, 2, 1, F3_SRL_SRA, 17), OPND_A, OPND_B, 32'hf876_5432);
        wb_row(r_type(7'h00, 2, 1, F3_OR, 18), OPND_A, OPND_B, 32'h8765_4325);
        wb_row(r_type(7'h00, 2, 1, F3_AND, 19), OPND_A, OPND_B, 32'h0000_0020);
        // rs2 value is junk for OP-IMM
        wb_row(i_type(12'hfff, 1, F3_ADD_SUB, 20, OPC_OP_IMM), OPND_A, 32'hdead_beef,
               32'h8765_4320);
        wb_row(i_type(12'h005, 1, F3_SLT, 21, OPC_OP_IMM), OPND_A, 32'hdead_beef, 32'h1);
        wb_row(i_type(12'hfff, 1, F3_SLTU, 22, OPC_OP_IMM), OPND_A, 32'hdead_beef, 32'h1);
        wb_row(i_type(12'h0ff, 1, F3_XOR, 23, OPC_OP_IMM), OPND_A, 0, 32'h8765_43de);
        wb_row(i_type(12'h700, 1, F3_OR, 24, OPC_OP_IMM), OPND_A, 0, 32'h8765_4721);
        wb_row(i_type(12'h0f0, 1, F3_AND, 25, OPC_OP_IMM), OPND_A, 0, 32'h0000_0020);
        wb_row(i_type(12'h008, 1, F3_SLL, 26, OPC_OP_IMM), OPND_A, 0, 32'h6543_2100);
        wb_row(i_type(12'h008, 1, F3_SRL_SRA, 27, OPC_OP_IMM), OPND_A, 0, 32'h0087_6543);
        wb_row(i_type(12'h408, 1, F3_SRL_SRA, 28, OPC_OP_IMM), OPND_A, 0, 32'hff87_6543);
        silent_row(r_type(7'h00, 2, 1, F3_ADD_SUB, 0), OPND_A, OPND_B);
        // x5 and x6 reach the next op only through forwarding
        wb_row(i_type(12'h010, 1, F3_ADD_SUB, 5, OPC_OP_IMM), OPND_A, 0, 32'h8765_4331);
        wb_row(r_type(7'h20, 2, 5, F3_ADD_SUB, 6), 0, OPND_B, 32'h8765_430d);
        wb_row(r_type(7'h00, 6, 1, F3_XOR, 7), OPND_A, 0, 32'h0000_002c);
        branch_row(b_type(13'h0010, F3_BEQ), 5, 5, 1'b1, 32'h0000_0010);
        branch_row(b_type(13'h1ff8, F3_BNE), 5, 5, 1'b0, 32'hffff_fff8);
        branch_row(b_type(13'h07fe, F3_BLT), 32'hffff_ffff, 1, 1'b1, 32'h0000_07fe);
        branch_row(b_type(13'h1000, F3_BGE), 32'hffff_ffff, 1, 1'b0, 32'hffff_f000);
        branch_row(b_type(13'h0ffe, F3_BLTU), 32'hffff_ffff, 1, 1'b0, 32'h0000_0ffe);
        branch_row(b_type(13'h000c, F3_BGEU), 32'hffff_ffff, 1, 1'b1, 32'h0000_000c);
        store_row(s_type(12'h000, F3_W), 32'h40, 32'hcafe_f00d, 32'h40, 4'b1111, 32'hcafe_f00d);
        store_row(s_type(12'h006, F3_H), 32'h40, 32'h1234_beef, 32'h46, 4'b1100, 32'hbeef_0000);
        store_row(s_type(12'hfff, F3_B), 32'h4c, 32'h5555_559a, 32'h4b, 4'b1000, 32'h9a00_0000);
        store_row(s_type(12'h001, F3_B), 32'h4c, 32'hffff_ff7f, 32'h4d, 4'b0010, 32'h0000_7f00);
        store_row(s_type(12'h000, F3_H), 32'h50, 32'haaaa_8001, 32'h50, 4'b0011, 32'h0000_8001);
        wb_row(i_type(12'h000, 1, F3_W, 10, OPC_LOAD), 32'h40, 0, 32'hcafe_f00d);
        wb_row(r_type(7'h00, 2, 1, F3_ADD_SUB, 25), 1, 2, 32'h0000_0003);
        wb_row(i_type(12'h006, 1, F3_H, 11, OPC_LOAD), 32'h40, 0, 32'hffff_beef);
        wb_row(i_type(12'h002, 1, F3_HU, 12, OPC_LOAD), 32'h44, 0, 32'h0000_beef);
        wb_row(i_type(12'h000, 1, F3_H, 13, OPC_LOAD), 32'h44, 0, 32'h0000_4544);
        wb_row(i_type(12'h000, 1, F3_HU, 14, OPC_LOAD), 32'h50, 0, 32'h0000_8001);
        wb_row(i_type(12'hfff, 1, F3_B, 15, OPC_LOAD), 32'h4c, 0, 32'hffff_ff9a);
        wb_row(i_type(12'h002, 1, F3_B, 16, OPC_LOAD), 32'h48, 0, 32'h0000_004a);
        wb_row(i_type(12'h001, 1, F3_B, 17, OPC_LOAD), 32'h4c, 0, 32'h0000_007f);
        wb_row(i_type(12'h000, 1, F3_B, 18, OPC_LOAD), 32'h80, 0, 32'hffff_ff80);
        wb_row(i_type(12'h003, 1, F3_BU, 19, OPC_LOAD), 32'h48, 0, 32'h0000_009a);
        wb_row(i_type(12'h000, 1, F3_BU, 20, OPC_LOAD), 32'h4c, 0, 32'h0000_004c);
        wb_row(i_type(12'h001, 1, F3_BU, 21, OPC_LOAD), 32'h48, 0, 32'h0000_0049);
        wb_row(i_type(12'h002, 1, F3_BU, 22, OPC_LOAD), 32'h80, 0, 32'h0000_0082);
        silent_row(i_type(12'h000, 1, F3_W, 0, OPC_LOAD), 32'h80, 0);
        wb_row(i_type(12'h000, 1, F3_W, 23, OPC_LOAD), 32'h80, 0, 32'h8382_8180);
        wb_row(r_type(7'h20, 2, 1, F3_ADD_SUB, 24), OPND_A, OPND_B, 32'h8765_42fd);
    endtask

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input logic [95:0] actual, input logic [95:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_now($sformatf("ERROR at %0t: %s mismatch, got %h expected %h",
                               $time, what, actual, expected));
        end
    endtask

    // Observe handshakes that complete at the coming rising edge
    task automatic observe_outputs();
        row_t        row;
        logic [31:0] load_addr;
        if (wb_valid && wb_ready) begin
            if (wb_exp.size() == 0) fail_now("A writeback appeared when none was expected");
            else check_value(wb, wb_exp.pop_front(), "writeback");
        end
        if (branch_valid && branch_ready) begin
            if (branch_exp.size() == 0) fail_now("A branch appeared when none was expected");
            else check_value(branch, branch_exp.pop_front(), "branch");
        end
        if (mem_req_valid && mem_req_ready) begin
            if (mem_exp.size() == 0) begin
                fail_now("A memory request appeared when none was expected");
            end else begin
                check_value(mem_req, mem_exp.pop_front(), "memory request");
                if (mem_req.read_enable) begin
                    rsp_due = 1'b1;
                    rsp_word = mem[mem_req.addr[5:0]];
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        if (mem_req.write_mask[i]) begin
                            mem[mem_req.addr[5:0]][8*i +: 8] = mem_req.data[8*i +: 8];
                        end
                    end
                end
            end
        end
        if (issue_valid && issue_ready) begin
            row = table_q[next_row];
            case (row.kind)
                KIND_WB:     wb_exp.push_back({row.instr[11:7], row.value});
                KIND_BRANCH: branch_exp.push_back({row.taken, row.value});
                KIND_STORE:  mem_exp.push_back({1'b0, row.mask, row.value[31:2], row.data});
                default: ;
            endcase
            // Loads read the word at rs1 plus the I-format offset
            if (row.instr[6:0] == OPC_LOAD) begin
                load_addr = row.rs1_value + {{20{row.instr[31]}}, row.instr[31:20]};
                mem_exp.push_back({1'b1, 4'b0000, load_addr[31:2], 32'h0});
            end
            next_row++;
        end
    endtask

    task automatic run_pass(input bit random_ready);
        int cycles;
        int idle;
        cycles = 0;
        idle = 0;
        next_row = 0;
        reset = 1'b1;
        issue_valid = 1'b0;
        mem_rsp_valid = 1'b0;
        rsp_due = 1'b0;
        for (int w = 0; w < 64; w++) begin
            mem[w] = w * 32'h0404_0404 + 32'h0302_0100;  // Each byte holds its own address
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        // A few idle cycles at the end catch late or repeated outputs
        while (idle < 8) begin
            cycles++;
            if (cycles > timeout_limit) begin
                fail_now($sformatf("Timeout: pass did not finish in %0d cycles", timeout_limit));
            end else begin
                mem_rsp_valid = rsp_due;
                mem_rsp_data = rsp_due ? rsp_word : '0;
                rsp_due = 1'b0;
                wb_ready = !random_ready || (($random(seed) & 3) != 0);
                branch_ready = !random_ready || (($random(seed) & 3) != 0);
                mem_req_ready = !random_ready || (($random(seed) & 3) != 0);
                issue_valid = (next_row < table_q.size());
                if (issue_valid) begin
                    issue = {table_q[next_row].instr, table_q[next_row].rs1_value,
                             table_q[next_row].rs2_value};
                end
                #2;
                observe_outputs();
                @(negedge clk);
                if (next_row < table_q.size() || wb_exp.size() != 0 || branch_exp.size() != 0
                    || mem_exp.size() != 0) begin
                    idle = 0;
                end else begin
                    idle++;
                end
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        mem_req_ready = 1'b1;
        branch_ready = 1'b1;
        wb_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        seed = 32'h5f7f_a36d;
        build_table();
        timeout_limit = 20 * table_q.size() + 200;
        run_pass(1'b0);
        run_pass(1'b1);  // Same table again under random back-pressure
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- all.f
+incdir+source
source/rv_exec_pkg.sv
source/rv_stream_reg.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_writeback.sv
source/rv_exec_top.sv
dv/rv_exec_tb.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - source
    files:
      - source/rv_exec_pkg.sv
      - source/rv_stream_reg.sv
      - source/rv_decode.sv
      - source/rv_execute.sv
      - source/rv_writeback.sv
      - source/rv_exec_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/rv_exec_tb.sv
